// File: source/bp_pkg.sv
/*
 * Shared definitions for the fetch-stage branch predictor.
 * Holds the predictor sizes, RISC-V opcodes, the instruction word views
 * and the structs that travel between fetch, execute and the predictor.
 */

package bp_pkg;

    // Address and instruction geometry
    localparam int ADDR_PC_BITS = 40;                  // Width of an instruction address
    typedef logic [ADDR_PC_BITS-1:0] addr_pc_t;
    localparam addr_pc_t INSTR_BYTES = 40'd4;          // Sequential step, no compressed

    // Return address stack
    localparam int RAS_DEPTH_LOG = 4;
    localparam int RAS_ENTRIES   = 2 ** RAS_DEPTH_LOG; // 16 entries

    // Branch target buffer, index taken from pc[6:2]
    localparam int BTB_INDEX_BITS = 5;
    localparam int BTB_ENTRIES    = 2 ** BTB_INDEX_BITS;
    // Tag keeps everything above the index plus the two alignment bits
    localparam int BTB_TAG_BITS   = ADDR_PC_BITS - BTB_INDEX_BITS;

    // Pattern history table, index taken from pc[8:2]
    localparam int PHT_INDEX_BITS = 7;
    localparam int PHT_ENTRIES    = 2 ** PHT_INDEX_BITS;
    localparam logic [1:0] PHT_WEAK_NT = 2'b01;        // Counter value out of reset

    // Link registers x1 (ra) and x5 (t0)
    localparam logic [4:0] LINK_REG_A = 5'd1;
    localparam logic [4:0] LINK_REG_B = 5'd5;

    // Control-flow opcodes
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Kind of control transfer stored per BTB entry
    typedef enum logic [1:0] {
        XFER_BRANCH = 2'd0,
        XFER_JUMP   = 2'd1,
        XFER_CALL   = 2'd2,
        XFER_RETURN = 2'd3
    } xfer_kind_t;

    typedef struct packed {
        logic [11:0] imm;     // imm[11:0]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [19:0] imm;     // Scrambled imm[20|10:1|11|19:12]
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_j_t;

    // Same 32-bit word seen as I-type (jalr) or J-type (jal)
    typedef union packed {
        instr_i_t i;
        instr_j_t j;
    } instr_u;

    typedef struct packed {
        logic     valid;
        addr_pc_t pc;
    } fetch_query_t;

    typedef struct packed {
        logic     taken;
        addr_pc_t target;      // pc + 4 when not taken
    } prediction_t;

    // Resolved outcome of one control instruction from execute
    typedef struct packed {
        logic     valid;       // One-cycle strobe
        addr_pc_t pc;
        instr_u   instr;
        logic     taken;
        addr_pc_t target;
    } exe_update_t;

endpackage

// File: source/return_address_stack.sv
/*
 * Circular 16-entry stack of return addresses.
 * Calls push the link address, returns pop it, and a combined push and
 * pop rewrites the top in place. Over- and underflow simply wrap.
 */

module return_address_stack import bp_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  addr_pc_t pc_link_i,          // Link address to push
    input  logic     push_i,
    input  logic     pop_i,
    output addr_pc_t return_address_o    // Current top of stack
);

    addr_pc_t                 stack_q [RAS_ENTRIES];
    logic [RAS_DEPTH_LOG-1:0] head_q;    // Next free slot
    logic [RAS_DEPTH_LOG-1:0] top_ptr;   // Most recent entry

    assign top_ptr = head_q - 1'b1;      // Wraps to 15 when head is 0

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            for (int i = 0; i < RAS_ENTRIES; i++) begin
                stack_q[i] <= '0;
            end
        end else if (push_i && pop_i) begin
            // Return followed by call, head stays put
            stack_q[top_ptr] <= pc_link_i;
        end else if (push_i) begin
            stack_q[head_q] <= pc_link_i;  // Oldest entry lost on overflow
            head_q          <= head_q + 1'b1;
        end else if (pop_i) begin
            head_q <= top_ptr;
        end
    end

    assign return_address_o = stack_q[top_ptr];

    // A lone push must be visible at the top one edge later
    property p_push_visible;
        @(posedge clk_i) disable iff (!rstn_i)
        (push_i && !pop_i) |=> (return_address_o == $past(pc_link_i));
    endproperty

    a_push_visible: assert property (p_push_visible)
        else $error("RAS top %h differs from pushed address %h",
                    return_address_o, $past(pc_link_i));

endmodule

// File: source/pattern_history_table.sv
/*
 * Direction predictor built from 128 two-bit saturating counters.
 * Fetch reads the counter for its PC in the same cycle, execute trains
 * the counter of a resolved conditional branch at the next edge.
 */

module pattern_history_table import bp_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  addr_pc_t rd_pc_i,            // Fetch PC
    output logic     taken_o,            // Counter MSB
    input  logic     wr_en_i,            // Train strobe
    input  addr_pc_t wr_pc_i,            // Resolved branch PC
    input  logic     wr_taken_i          // Resolved direction
);

    logic [1:0]                ctr_q [PHT_ENTRIES];
    logic [PHT_INDEX_BITS-1:0] rd_idx;
    logic [PHT_INDEX_BITS-1:0] wr_idx;
    logic [1:0]                wr_ctr;       // Counter being trained
    logic [1:0]                wr_ctr_next;

    // Skip the two alignment bits
    assign rd_idx = rd_pc_i[PHT_INDEX_BITS+1:2];
    assign wr_idx = wr_pc_i[PHT_INDEX_BITS+1:2];

    // Weakly/strongly taken share bit 1
    assign taken_o = ctr_q[rd_idx][1];

    assign wr_ctr = ctr_q[wr_idx];

    // Saturating step
    always_comb begin
        wr_ctr_next = wr_ctr;
        if (wr_taken_i) begin
            if (wr_ctr != 2'b11) wr_ctr_next = wr_ctr + 2'd1;
        end else begin
            if (wr_ctr != 2'b00) wr_ctr_next = wr_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                ctr_q[i] <= PHT_WEAK_NT;   // Start weakly not taken
            end
        end else if (wr_en_i) begin
            ctr_q[wr_idx] <= wr_ctr_next;  // Same-cycle reader still sees old value
        end
    end

    // Taken training never wraps a counter round to 0
    property p_no_wrap_up;
        @(posedge clk_i) disable iff (!rstn_i)
        (wr_en_i && wr_taken_i) |=> (ctr_q[$past(wr_idx)] != 2'b00);
    endproperty

    // Not-taken training never wraps a counter round to 3
    property p_no_wrap_down;
        @(posedge clk_i) disable iff (!rstn_i)
        (wr_en_i && !wr_taken_i) |=> (ctr_q[$past(wr_idx)] != 2'b11);
    endproperty

    a_no_wrap_up: assert property (p_no_wrap_up)
        else $error("PHT counter wrapped above 3 at index %0d", $past(wr_idx));

    a_no_wrap_down: assert property (p_no_wrap_down)
        else $error("PHT counter wrapped below 0 at index %0d", $past(wr_idx));

endmodule

// File: source/branch_target_buffer.sv
/*
 * Direct-mapped branch target buffer with 32 entries.
 * Each entry stores a tag, the taken target and the transfer kind, so
 * fetch can tell branches, jumps, calls and returns apart before decode.
 */

module branch_target_buffer import bp_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  addr_pc_t   rd_pc_i,          // Fetch PC
    output logic       hit_o,
    output addr_pc_t   target_o,
    output xfer_kind_t kind_o,
    input  logic       wr_en_i,          // Taken update from execute
    input  addr_pc_t   wr_pc_i,
    input  addr_pc_t   wr_target_i,
    input  xfer_kind_t wr_kind_i
);

    // Payload of one entry, valid kept apart so only it needs reset
    typedef struct packed {
        logic [BTB_TAG_BITS-1:0] tag;
        addr_pc_t                target;
        xfer_kind_t              kind;
    } btb_entry_t;

    logic [BTB_ENTRIES-1:0]    valid_q;
    btb_entry_t                entry_q [BTB_ENTRIES];

    logic [BTB_INDEX_BITS-1:0] rd_idx;
    logic [BTB_INDEX_BITS-1:0] wr_idx;
    logic [BTB_TAG_BITS-1:0]   rd_tag;
    logic [BTB_TAG_BITS-1:0]   wr_tag;
    btb_entry_t                rd_entry;

    // Index is pc[6:2]
    assign rd_idx = rd_pc_i[BTB_INDEX_BITS+1:2];
    assign wr_idx = wr_pc_i[BTB_INDEX_BITS+1:2];

    // Tag is the upper bits joined with the alignment bits
    assign rd_tag = {rd_pc_i[ADDR_PC_BITS-1:BTB_INDEX_BITS+2], rd_pc_i[1:0]};
    assign wr_tag = {wr_pc_i[ADDR_PC_BITS-1:BTB_INDEX_BITS+2], wr_pc_i[1:0]};

    // Asynchronous read
    assign rd_entry = entry_q[rd_idx];
    assign hit_o    = valid_q[rd_idx] && (rd_entry.tag == rd_tag);
    assign target_o = rd_entry.target;
    assign kind_o   = rd_entry.kind;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Newest update replaces whatever sat at the index
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            entry_q[wr_idx] <= '{tag: wr_tag, target: wr_target_i, kind: wr_kind_i};
        end
    end

    // Targets are at least halfword aligned
    property p_target_aligned;
        @(posedge clk_i) disable iff (!rstn_i)
        wr_en_i |-> (wr_target_i[0] == 1'b0);
    endproperty

    a_target_aligned: assert property (p_target_aligned)
        else $error("BTB write with odd target %h", wr_target_i);

endmodule

// File: source/link_decoder.sv
/*
 * Classifies a resolved control instruction from execute.
 * Follows the RISC-V link register hints to decide stack pushes and pops,
 * and returns the transfer kind and the link address for the stack.
 */

module link_decoder import bp_pkg::*; (
    input  exe_update_t upd_i,
    output xfer_kind_t  kind_o,
    output logic        push_o,          // Call, already gated by valid
    output logic        pop_o,           // Return, already gated by valid
    output addr_pc_t    link_addr_o      // pc + 4
);

    logic is_jal;
    logic is_jalr;
    logic is_jump;
    logic rd_link;                       // rd names x1 or x5
    logic rs1_link;
    logic is_call;
    logic is_return;

    assign is_jal  = (upd_i.instr.j.opcode == OPC_JAL);
    assign is_jalr = (upd_i.instr.i.opcode == OPC_JALR);
    assign is_jump = is_jal || is_jalr;

    // rd sits at the same bits in both views
    assign rd_link  = (upd_i.instr.j.rd == LINK_REG_A) || (upd_i.instr.j.rd == LINK_REG_B);
    assign rs1_link = (upd_i.instr.i.rs1 == LINK_REG_A) || (upd_i.instr.i.rs1 == LINK_REG_B);

    assign is_call = is_jump && rd_link;

    // Same link reg in rd and rs1 means a plain call
    assign is_return = is_jalr && rs1_link &&
                       !(rd_link && (upd_i.instr.i.rd == upd_i.instr.i.rs1));

    always_comb begin
        kind_o = XFER_BRANCH;              // Conditional branch or anything else
        if (is_jump) begin
            if (is_return) begin
                kind_o = XFER_RETURN;      // Also covers pop-then-push
            end else if (is_call) begin
                kind_o = XFER_CALL;
            end else begin
                kind_o = XFER_JUMP;
            end
        end
    end

    assign push_o      = upd_i.valid && is_call;
    assign pop_o       = upd_i.valid && is_return;
    assign link_addr_o = upd_i.pc + INSTR_BYTES;

    // Stack traffic only ever comes from jal or jalr words
    always_comb begin
        a_stack_on_jump: assert final (!(push_o || pop_o) ||
                                       upd_i.instr.i.opcode inside {OPC_JAL, OPC_JALR})
            else $error("Stack push/pop on non-jump opcode %b", upd_i.instr.i.opcode);
    end

endmodule

// File: source/branch_predictor.sv
/*
 * Branch prediction unit of the fetch stage.
 * Combines the BTB, the direction counters and the return address stack
 * into a same-cycle prediction, and trains all three from execute.
 */

module branch_predictor import bp_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  fetch_query_t fetch_i,        // PC presented by fetch
    output prediction_t  pred_o,         // Same-cycle prediction
    input  exe_update_t  exe_i           // Resolved control instruction
);

    xfer_kind_t upd_kind;                // Decoded kind of the update
    logic       ras_push;
    logic       ras_pop;
    addr_pc_t   link_addr;
    addr_pc_t   ras_top;

    logic       pht_taken;
    logic       btb_hit;
    addr_pc_t   btb_target;
    xfer_kind_t btb_kind;
    addr_pc_t   fetch_seq_pc;            // Fall-through address

    link_decoder i_link_decoder (
        .upd_i       (exe_i),
        .kind_o      (upd_kind),
        .push_o      (ras_push),
        .pop_o       (ras_pop),
        .link_addr_o (link_addr)
    );

    return_address_stack i_return_address_stack (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .pc_link_i        (link_addr),
        .push_i           (ras_push),
        .pop_i            (ras_pop),
        .return_address_o (ras_top)
    );

    // Only conditional branches train direction
    pattern_history_table i_pattern_history_table (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rd_pc_i    (fetch_i.pc),
        .taken_o    (pht_taken),
        .wr_en_i    (exe_i.valid && (upd_kind == XFER_BRANCH)),
        .wr_pc_i    (exe_i.pc),
        .wr_taken_i (exe_i.taken)
    );

    // Not-taken branches leave the BTB alone
    branch_target_buffer i_branch_target_buffer (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .rd_pc_i     (fetch_i.pc),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .kind_o      (btb_kind),
        .wr_en_i     (exe_i.valid && exe_i.taken),
        .wr_pc_i     (exe_i.pc),
        .wr_target_i (exe_i.target),
        .wr_kind_i   (upd_kind)
    );

    assign fetch_seq_pc = fetch_i.pc + INSTR_BYTES;

    // Final selection, default is fall-through
    always_comb begin
        pred_o.taken  = 1'b0;
        pred_o.target = fetch_seq_pc;
        if (fetch_i.valid && btb_hit) begin
            unique case (btb_kind)
                XFER_RETURN: begin
                    pred_o.taken  = 1'b1;
                    pred_o.target = ras_top;   // Stack beats the stored target
                end
                XFER_JUMP, XFER_CALL: begin
                    pred_o.taken  = 1'b1;
                    pred_o.target = btb_target;
                end
                XFER_BRANCH: begin
                    if (pht_taken) begin
                        pred_o.taken  = 1'b1;
                        pred_o.target = btb_target;
                    end
                end
            endcase
        end
    end

endmodule

// File: testbench/tb_branch_predictor.sv
/*
 * Self-checking testbench for the fetch-stage branch predictor.
 * A reference model of stack, counters and BTB drives concurrent checks on
 * every prediction, while directed tests walk through training and returns.
 */

module tb_branch_predictor import bp_pkg::*; ();

    logic         clk_i;
    logic         rstn_i;
    fetch_query_t fetch_i;
    prediction_t  pred_o;
    exe_update_t  exe_i;

    // Reference model state
    addr_pc_t                  ras_m [RAS_ENTRIES];
    logic [RAS_DEPTH_LOG-1:0]  ras_head_m;
    logic [RAS_DEPTH_LOG-1:0]  ras_top_m;
    logic [1:0]                pht_m [PHT_ENTRIES];
    logic [BTB_ENTRIES-1:0]    btb_valid_m;
    addr_pc_t                  btb_pc_m [BTB_ENTRIES];     // Full PC stands in for the tag
    addr_pc_t                  btb_target_m [BTB_ENTRIES];
    xfer_kind_t                btb_kind_m [BTB_ENTRIES];
    logic [BTB_INDEX_BITS-1:0] q_bidx;
    logic [PHT_INDEX_BITS-1:0] q_pidx;
    logic                      q_hit;
    prediction_t               exp_pred;

    integer seed;
    int     checks;
    int     errors;
    int     errors_at_start;
    int     test_num;

    branch_predictor i_branch_predictor (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .fetch_i (fetch_i),
        .pred_o  (pred_o),
        .exe_i   (exe_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic is_link(input logic [4:0] r);
        return (r == LINK_REG_A) || (r == LINK_REG_B);
    endfunction

    // Transfer kind and stack action taken straight from the raw word
    function automatic void classify(input logic [31:0] w, output xfer_kind_t kind,
                                     output logic push, output logic pop);
        logic [4:0] rd;
        logic [4:0] rs1;
        rd   = w[11:7];
        rs1  = w[19:15];
        push = 1'b0;
        pop  = 1'b0;
        kind = XFER_BRANCH;
        if (w[6:0] == OPC_JAL) begin
            push = is_link(rd);
            kind = push ? XFER_CALL : XFER_JUMP;
        end else if (w[6:0] == OPC_JALR) begin
            push = is_link(rd);
            pop  = is_link(rs1) && !(push && (rd == rs1));  // Same link reg is a call only
            kind = pop ? XFER_RETURN : (push ? XFER_CALL : XFER_JUMP);
        end
    endfunction

    assign ras_top_m = ras_head_m - 1'b1;

    always @(posedge clk_i) begin : model_update
        xfer_kind_t                kind;
        logic                      push;
        logic                      pop;
        logic [BTB_INDEX_BITS-1:0] bidx;
        logic [PHT_INDEX_BITS-1:0] pidx;
        if (!rstn_i) begin
            ras_head_m  <= '0;
            btb_valid_m <= '0;
            for (int i = 0; i < RAS_ENTRIES; i++) begin
                ras_m[i] <= '0;
            end
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_m[i] <= 2'b01;                    // Weakly not taken
            end
        end else if (exe_i.valid) begin
            classify(exe_i.instr, kind, push, pop);
            bidx = exe_i.pc[BTB_INDEX_BITS+1:2];
            pidx = exe_i.pc[PHT_INDEX_BITS+1:2];
            if (push && pop) begin
                ras_m[ras_top_m] <= exe_i.pc + 40'd4; // Replace top in place
            end else if (push) begin
                ras_m[ras_head_m] <= exe_i.pc + 40'd4;
                ras_head_m        <= ras_head_m + 1'b1;
            end else if (pop) begin
                ras_head_m <= ras_top_m;
            end
            if (kind == XFER_BRANCH) begin
                if (exe_i.taken && pht_m[pidx] != 2'b11) pht_m[pidx] <= pht_m[pidx] + 2'd1;
                if (!exe_i.taken && pht_m[pidx] != 2'b00) pht_m[pidx] <= pht_m[pidx] - 2'd1;
            end
            if (exe_i.taken) begin
                btb_valid_m[bidx]  <= 1'b1;
                btb_pc_m[bidx]     <= exe_i.pc;
                btb_target_m[bidx] <= exe_i.target;
                btb_kind_m[bidx]   <= kind;
            end
        end
    end

    assign q_bidx = fetch_i.pc[BTB_INDEX_BITS+1:2];
    assign q_pidx = fetch_i.pc[PHT_INDEX_BITS+1:2];
    assign q_hit  = fetch_i.valid && btb_valid_m[q_bidx] && (btb_pc_m[q_bidx] == fetch_i.pc);

    // Expected same-cycle prediction
    always_comb begin
        exp_pred.taken  = 1'b0;
        exp_pred.target = fetch_i.pc + 40'd4;
        if (q_hit) begin
            if (btb_kind_m[q_bidx] == XFER_RETURN) begin
                exp_pred.taken  = 1'b1;
                exp_pred.target = ras_m[ras_top_m];
            end else if (btb_kind_m[q_bidx] != XFER_BRANCH || pht_m[q_pidx][1]) begin
                exp_pred.taken  = 1'b1;
                exp_pred.target = btb_target_m[q_bidx];
            end
        end
    end

    a_pred_taken: assert property (@(posedge clk_i) disable iff (!rstn_i)
                                   pred_o.taken == exp_pred.taken)
        checks++;
    else begin
        errors++;
        $display("FAILED pred_o.taken expected %h actual %h",
                 $sampled(exp_pred.taken), $sampled(pred_o.taken));
    end

    a_pred_target: assert property (@(posedge clk_i) disable iff (!rstn_i)
                                    pred_o.target == exp_pred.target)
        checks++;
    else begin
        errors++;
        $display("FAILED pred_o.target expected %h actual %h",
                 $sampled(exp_pred.target), $sampled(pred_o.target));
    end

    function automatic addr_pc_t random_pc();
        logic [63:0] raw;
        addr_pc_t    pc;
        raw   = {$random(seed), $random(seed)};
        pc    = raw[ADDR_PC_BITS-1:0];
        pc[0] = 1'b0;                             // At least halfword aligned
        return pc;
    endfunction

    // Random PC on another BTB index, so the return site entry survives
    function automatic addr_pc_t pc_away_from(input addr_pc_t avoid);
        addr_pc_t pc;
        pc    = random_pc();
        pc[2] = ~avoid[2];
        return pc;
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd);
        return {20'h0, rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'h0, rs1, 3'b000, rd, OPC_JALR};
    endfunction

    function automatic logic [31:0] branch_word();
        return {25'h0, OPC_BRANCH};
    endfunction

    // One-cycle update strobe, visible from the following edge
    task automatic apply_update(input addr_pc_t pc, input logic [31:0] word,
                                input logic taken, input addr_pc_t target);
        @(posedge clk_i);
        exe_i <= '{valid: 1'b1, pc: pc, instr: word, taken: taken, target: target};
        @(posedge clk_i);
        exe_i.valid <= 1'b0;
    endtask

    // Present a PC and let the next edge sample the prediction
    task automatic query_pc(input addr_pc_t pc, input logic valid);
        @(posedge clk_i);
        fetch_i <= '{valid: valid, pc: pc};
        @(posedge clk_i);
        @(negedge clk_i);                         // Assertion actions have run by now
    endtask

    task automatic begin_test();
        test_num++;
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        a_test_clean: assert (errors == errors_at_start)
            $display("Test %0d %s: pass", test_num, name);
        else
            $display("Test %0d %s: %0d mismatches", test_num, name, errors - errors_at_start);
    endtask

    initial begin
        addr_pc_t pc_a;
        addr_pc_t pc_b;
        addr_pc_t pc_c;
        addr_pc_t pc_r;                            // Return site shared by tests 4 to 6
        addr_pc_t tgt;
        addr_pc_t call_pc [17];
        seed     = 19187;
        checks   = 0;
        errors   = 0;
        test_num = 0;
        rstn_i   = 1'b0;
        fetch_i  = '0;
        exe_i    = '0;
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;

        begin_test();
        for (int i = 0; i < 8; i++) begin
            query_pc(random_pc(), (i % 2) == 0);   // Every other query invalid
        end
        end_test("reset defaults");

        begin_test();
        pc_a = random_pc();
        tgt  = random_pc();
        apply_update(pc_a, branch_word(), 1'b1, tgt);
        query_pc(pc_a, 1'b1);                      // Counter at 10
        apply_update(pc_a, branch_word(), 1'b1, tgt);
        query_pc(pc_a, 1'b1);                      // Saturated at 11
        apply_update(pc_a, branch_word(), 1'b0, pc_a + 40'd4);
        query_pc(pc_a, 1'b1);
        apply_update(pc_a, branch_word(), 1'b0, pc_a + 40'd4);
        query_pc(pc_a, 1'b1);                      // Back to 01, falls through
        end_test("direction training");

        begin_test();
        pc_a = random_pc();
        query_pc(pc_a, 1'b1);
        apply_update(pc_a, jal_word(5'd0), 1'b1, random_pc());
        query_pc(pc_a, 1'b1);
        query_pc(pc_a ^ (40'h1 << 20), 1'b1);      // Same index, other tag
        end_test("jump and alias");

        begin_test();
        pc_r = random_pc();
        pc_a = random_pc();
        // Teach the BTB that pc_r is a return before the real sequence
        apply_update(pc_a, jal_word(LINK_REG_A), 1'b1, random_pc());
        apply_update(pc_r, jalr_word(5'd0, LINK_REG_A), 1'b1, pc_a + 40'd4);
        for (int i = 0; i < 3; i++) begin
            call_pc[i] = pc_away_from(pc_r);
            apply_update(call_pc[i], jal_word(LINK_REG_A), 1'b1, random_pc());
        end
        for (int i = 0; i < 3; i++) begin
            query_pc(pc_r, 1'b1);                  // C, B, A plus 4
            apply_update(pc_r, jalr_word(5'd0, LINK_REG_A), 1'b1, call_pc[2-i] + 40'd4);
        end
        end_test("LIFO returns");

        begin_test();
        for (int i = 0; i < 17; i++) begin
            call_pc[i] = pc_away_from(pc_r);
            apply_update(call_pc[i], jal_word(LINK_REG_A), 1'b1, random_pc());
        end
        for (int i = 0; i < 17; i++) begin
            query_pc(pc_r, 1'b1);                  // Last one wraps onto the 17th call
            apply_update(pc_r, jalr_word(5'd0, LINK_REG_A), 1'b1, exp_pred.target);
        end
        end_test("stack overflow");

        begin_test();
        pc_a = pc_away_from(pc_r);
        pc_b = pc_away_from(pc_r);
        pc_c = pc_away_from(pc_r);
        apply_update(pc_a, jal_word(LINK_REG_A), 1'b1, random_pc());
        apply_update(pc_b, jal_word(LINK_REG_A), 1'b1, random_pc());
        apply_update(pc_c, jalr_word(LINK_REG_A, LINK_REG_B), 1'b1, random_pc());
        query_pc(pc_r, 1'b1);                      // Top now pc_c plus 4
        apply_update(pc_r, jalr_word(5'd0, LINK_REG_A), 1'b1, exp_pred.target);
        query_pc(pc_r, 1'b1);                      // Entry below still pc_a plus 4
        end_test("pop and push replace");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: project.f
source/bp_pkg.sv
source/return_address_stack.sv
source/pattern_history_table.sv
source/branch_target_buffer.sv
source/link_decoder.sv
source/branch_predictor.sv
testbench/tb_branch_predictor.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  - source/bp_pkg.sv
  - source/return_address_stack.sv
  - source/pattern_history_table.sv
  - source/branch_target_buffer.sv
  - source/link_decoder.sv
  - source/branch_predictor.sv
  - target: simulation
    files:
      - testbench/tb_branch_predictor.sv
